// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= tb_rename_top
FILE_LIST ?= verilog.f
BUILD_DIR ?= obj_dir
JOBS ?= 0
VFLAGS ?= --binary --timing --assert

SOURCES := $(shell cat $(FILE_LIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILE_LIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILE_LIST)

run: compile
	./$(SIM_BIN)

clean:
	rm -rf $(BUILD_DIR)

// ==== src/free_list.sv ====
`timescale 1ns/1ps

module free_list #(
    parameter int width = 2
) (
    input  logic                       clock,
    input  logic                       reset,
    input  logic           [width-1:0] alloc_req,
    output rename_pkg::PRN [width-1:0] alloc_prn,
    output logic                       stall,
    input  logic           [width-1:0] release_valid,
    input  rename_pkg::PRN [width-1:0] release_prn
);
    import rename_pkg::*;

    localparam int ptr_w = $clog2(free_list_sz);
    localparam int cnt_w = $clog2(free_list_sz + 1);
    localparam int lane_w = $clog2(width + 1);

    PRN fifo [free_list_sz];
    logic [ptr_w-1:0] head;
    logic [ptr_w-1:0] tail;
    logic [cnt_w-1:0] count;
    logic [cnt_w-1:0] alloc_taken;
    logic [lane_w-1:0] req_total;
    logic [lane_w-1:0] rel_total;
    logic [ptr_w-1:0] alloc_addr [width];
    logic [ptr_w-1:0] rel_addr [width];
    logic [width-1:0] rel_en;

    // requesting lanes take consecutive slots from the head
    always_comb begin
        req_total = '0;
        for (int i = 0; i < width; i++) begin
            alloc_addr[i] = head + ptr_w'(req_total);
            req_total = req_total + lane_w'(alloc_req[i]);
        end
    end

    // non-zero releases pack onto the tail in lane order
    always_comb begin
        rel_total = '0;
        for (int i = 0; i < width; i++) begin
            rel_en[i] = release_valid[i] && release_prn[i] != '0;
            rel_addr[i] = tail + ptr_w'(rel_total);
            rel_total = rel_total + lane_w'(rel_en[i]);
        end
    end

    // releases of this cycle are not yet counted
    assign stall = count < cnt_w'(req_total);
    assign alloc_taken = stall ? '0 : cnt_w'(req_total);

    always_comb begin
        for (int i = 0; i < width; i++) begin
            alloc_prn[i] = (alloc_req[i] && !stall) ? fifo[alloc_addr[i]] : '0;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            // full list of the registers above the architectural set
            for (int i = 0; i < free_list_sz; i++) begin
                fifo[i] <= PRN'(arch_reg_sz + i);
            end
            head <= '0;
            tail <= '0;
            count <= cnt_w'(free_list_sz);
        end else begin
            for (int i = 0; i < width; i++) begin
                if (rel_en[i]) begin
                    fifo[rel_addr[i]] <= release_prn[i];
                end
            end
            head <= head + ptr_w'(alloc_taken);
            tail <= tail + ptr_w'(rel_total);
            count <= count - alloc_taken + cnt_w'(rel_total);
        end
    end

endmodule

// ==== src/map_table.sv ====
`timescale 1ns/1ps

module map_table #(
    parameter int width = 2
) (
    input  logic                       clock,
    input  logic                       reset,
    input  logic           [width-1:0] rename_valid,
    input  rename_pkg::ARN [width-1:0] dest,
    input  rename_pkg::ARN [width-1:0] src1,
    input  rename_pkg::ARN [width-1:0] src2,
    input  rename_pkg::PRN [width-1:0] new_prn,
    input  logic                       stall,
    output logic           [width-1:0] alloc_req,
    output rename_pkg::PRN [width-1:0] src1_prn,
    output rename_pkg::PRN [width-1:0] src2_prn,
    output rename_pkg::PRN [width-1:0] old_prn
);
    import rename_pkg::*;

    PRN mapping [arch_reg_sz];

    // arch register 0 is never renamed
    for (genvar i = 0; i < width; i++) begin : g_req
        assign alloc_req[i] = rename_valid[i] && dest[i] != '0;
    end

    always_comb begin
        for (int i = 0; i < width; i++) begin
            src1_prn[i] = mapping[src1[i]];
            src2_prn[i] = mapping[src2[i]];
            old_prn[i] = mapping[dest[i]];
            // the newest earlier lane writing the register wins
            for (int j = 0; j < i; j++) begin
                if (alloc_req[j] && dest[j] == src1[i]) begin
                    src1_prn[i] = new_prn[j];
                end
                if (alloc_req[j] && dest[j] == src2[i]) begin
                    src2_prn[i] = new_prn[j];
                end
                if (alloc_req[j] && dest[j] == dest[i]) begin
                    old_prn[i] = new_prn[j];
                end
            end
            if (!alloc_req[i]) begin
                old_prn[i] = '0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int r = 0; r < arch_reg_sz; r++) begin
                mapping[r] <= PRN'(r);
            end
        end else if (!stall) begin
            // lane order, so the last write to a register sticks
            for (int i = 0; i < width; i++) begin
                if (alloc_req[i]) begin
                    mapping[dest[i]] <= new_prn[i];
                end
            end
        end
    end

endmodule

// ==== src/prf.sv ====
`timescale 1ns/1ps

module prf #(
    parameter int width = 2
) (
    input  logic                            clock,
    input  logic                            reset,
    input  rename_pkg::PRN  [2*width-1:0]   read_prn,
    output rename_pkg::DATA [2*width-1:0]   read_value,
    output logic            [2*width-1:0]   read_ready,
    input  rename_pkg::PRN  [width-1:0]     write_prn,
    input  rename_pkg::DATA [width-1:0]     write_value,
    input  rename_pkg::PRN  [width-1:0]     invalid_prn,
    input  rename_pkg::PRN  [width-1:0]     wb_read_prn,
    output rename_pkg::DATA [width-1:0]     wb_read_value,
    output logic            [width-1:0]     wb_read_ready,
    output logic [$bits(rename_pkg::PRN):0] ready_count
);
    import rename_pkg::*;

    localparam int cnt_w = $bits(PRN) + 1;

    DATA values [phys_reg_sz];
    logic [phys_reg_sz-1:0] ready;
    logic [phys_reg_sz-1:0] next_ready;
    logic [width-1:0] write_en;
    logic [cnt_w-1:0] next_count;

    // writes to the zero register are dropped
    always_comb begin
        for (int i = 0; i < width; i++) begin
            write_en[i] = write_prn[i] != '0;
        end
    end

    // issue reads, a same-cycle writeback is forwarded
    always_comb begin
        for (int i = 0; i < 2 * width; i++) begin
            read_value[i] = values[read_prn[i]];
            read_ready[i] = ready[read_prn[i]];
            for (int j = 0; j < width; j++) begin
                if (write_en[j] && write_prn[j] == read_prn[i]) begin
                    read_value[i] = write_value[j];
                    read_ready[i] = 1'b1;
                end
            end
        end
    end

    // writeback side reads stored state only
    always_comb begin
        for (int i = 0; i < width; i++) begin
            wb_read_value[i] = values[wb_read_prn[i]];
            wb_read_ready[i] = ready[wb_read_prn[i]];
        end
    end

    // writes first, then invalidations so they win on a collision
    always_comb begin
        next_ready = ready;
        next_count = ready_count;
        for (int i = 0; i < width; i++) begin
            if (write_en[i] && !next_ready[write_prn[i]]) begin
                next_ready[write_prn[i]] = 1'b1;
                next_count = next_count + 1'b1;
            end
        end
        for (int i = 0; i < width; i++) begin
            if (invalid_prn[i] != '0 && next_ready[invalid_prn[i]]) begin
                next_ready[invalid_prn[i]] = 1'b0;
                next_count = next_count - 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < phys_reg_sz; i++) begin
                values[i] <= '0;
                ready[i] <= (i < arch_reg_sz);
            end
            ready_count <= cnt_w'(arch_reg_sz);
        end else begin
            // later lane wins on a duplicate write
            for (int i = 0; i < width; i++) begin
                if (write_en[i]) begin
                    values[write_prn[i]] <= write_value[i];
                end
            end
            ready <= next_ready;
            ready_count <= next_count;
        end
    end

endmodule

// ==== src/rename_pkg.sv ====
package rename_pkg;

    // register counts
    localparam int arch_reg_sz = 32;
    localparam int phys_reg_sz = 64;

    // width of one register value
    localparam int data_width = 32;

    // free list depth, one slot per non-architectural register
    localparam int free_list_sz = phys_reg_sz - arch_reg_sz;

    // architectural register number
    typedef logic [$clog2(arch_reg_sz)-1:0] ARN;

    // physical register number, 0 is the zero register
    typedef logic [$clog2(phys_reg_sz)-1:0] PRN;

    // register value
    typedef logic [data_width-1:0] DATA;

endpackage

// ==== src/rename_top.sv ====
`timescale 1ns/1ps

module rename_top #(
    parameter int width = 2
) (
    input  logic                            clock,
    input  logic                            reset,
    input  logic            [width-1:0]     rename_valid,
    input  rename_pkg::ARN  [width-1:0]     rename_dest,
    input  rename_pkg::ARN  [width-1:0]     rename_src1,
    input  rename_pkg::ARN  [width-1:0]     rename_src2,
    output rename_pkg::PRN  [width-1:0]     src1_prn,
    output rename_pkg::PRN  [width-1:0]     src2_prn,
    output rename_pkg::PRN  [width-1:0]     dest_prn,
    output rename_pkg::PRN  [width-1:0]     old_prn,
    output logic                            rename_stall,
    input  logic            [width-1:0]     commit_valid,
    input  rename_pkg::PRN  [width-1:0]     commit_old_prn,
    input  rename_pkg::PRN  [width-1:0]     write_prn,
    input  rename_pkg::DATA [width-1:0]     write_value,
    input  rename_pkg::PRN  [2*width-1:0]   read_prn,
    output rename_pkg::DATA [2*width-1:0]   read_value,
    output logic            [2*width-1:0]   read_ready,
    input  rename_pkg::PRN  [width-1:0]     wb_read_prn,
    output rename_pkg::DATA [width-1:0]     wb_read_value,
    output logic            [width-1:0]     wb_read_ready,
    output logic [$bits(rename_pkg::PRN):0] ready_count
);
    import rename_pkg::*;

    // lanes that need a new physical register
    logic [width-1:0] alloc_req;

    map_table #(.width(width)) i_map_table (
        .clock        (clock),
        .reset        (reset),
        .rename_valid (rename_valid),
        .dest         (rename_dest),
        .src1         (rename_src1),
        .src2         (rename_src2),
        .new_prn      (dest_prn),
        .stall        (rename_stall),
        .alloc_req    (alloc_req),
        .src1_prn     (src1_prn),
        .src2_prn     (src2_prn),
        .old_prn      (old_prn)
    );

    // committed old mappings go back to the free list
    free_list #(.width(width)) i_free_list (
        .clock         (clock),
        .reset         (reset),
        .alloc_req     (alloc_req),
        .alloc_prn     (dest_prn),
        .stall         (rename_stall),
        .release_valid (commit_valid),
        .release_prn   (commit_old_prn)
    );

    // fresh destinations turn not ready at the next edge
    prf #(.width(width)) i_prf (
        .clock         (clock),
        .reset         (reset),
        .read_prn      (read_prn),
        .read_value    (read_value),
        .read_ready    (read_ready),
        .write_prn     (write_prn),
        .write_value   (write_value),
        .invalid_prn   (dest_prn),
        .wb_read_prn   (wb_read_prn),
        .wb_read_value (wb_read_value),
        .wb_read_ready (wb_read_ready),
        .ready_count   (ready_count)
    );

endmodule

// ==== testbench/tb_rename_top.sv ====
`timescale 1ns/1ps

module tb_rename_top;
    import rename_pkg::*;

    localparam int width = 2;
    localparam int cnt_w = $bits(PRN) + 1;
    // tests take under 800 cycles, so this leaves ample margin
    localparam int max_cycles = 2000;

    logic clock = 1'b0;
    logic reset;
    logic [width-1:0] rename_valid, commit_valid;
    ARN [width-1:0] rename_dest, rename_src1, rename_src2;
    PRN [width-1:0] src1_prn, src2_prn, dest_prn, old_prn;
    PRN [width-1:0] commit_old_prn, write_prn, wb_read_prn;
    DATA [width-1:0] write_value, wb_read_value;
    PRN [2*width-1:0] read_prn;
    DATA [2*width-1:0] read_value;
    logic [2*width-1:0] read_ready;
    logic [width-1:0] wb_read_ready;
    logic rename_stall;
    logic [cnt_w-1:0] ready_count;

    // next inputs chosen before they are driven
    logic [width-1:0] n_valid, n_commit;
    ARN [width-1:0] n_dest, n_src1, n_src2;
    PRN [width-1:0] n_old, n_wprn, n_wbprn;
    DATA [width-1:0] n_wval;
    PRN [2*width-1:0] n_rprn;

    // reference model state and its predictions
    PRN ref_map [arch_reg_sz];
    PRN fl [4096];
    int fl_head;
    int fl_tail;
    DATA ref_val [phys_reg_sz];
    logic [phys_reg_sz-1:0] ref_rdy;
    PRN pending [$];
    PRN [width-1:0] exp_src1, exp_src2, exp_dest, exp_old;
    DATA [2*width-1:0] exp_rval;
    logic [2*width-1:0] exp_rrdy;
    DATA [width-1:0] exp_wbval;
    logic [width-1:0] exp_wbrdy;
    logic exp_stall;
    logic [cnt_w-1:0] exp_count;
    logic [31:0] seed;
    string test_name;
    int cycles = 0;

    rename_top #(.width(width)) i_rename_top (.*);

    always #5 clock = ~clock;

    function automatic int unsigned next_random();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed >> 8;
    endfunction

    task automatic report_mismatch(string what, logic [255:0] expected, logic [255:0] actual);
        $display("FAILED %s %s expected %0h actual %0h", test_name, what, expected, actual);
        $display("TB FAILED");
        $fatal(1, "output mismatch");
    endtask

    // outputs are compared mid-cycle, away from the driving edge
    check_src1: assert property (@(negedge clock) disable iff (reset) src1_prn == exp_src1)
        else report_mismatch("src1_prn", 256'(exp_src1), 256'(src1_prn));
    check_src2: assert property (@(negedge clock) disable iff (reset) src2_prn == exp_src2)
        else report_mismatch("src2_prn", 256'(exp_src2), 256'(src2_prn));
    check_dest: assert property (@(negedge clock) disable iff (reset) dest_prn == exp_dest)
        else report_mismatch("dest_prn", 256'(exp_dest), 256'(dest_prn));
    check_old: assert property (@(negedge clock) disable iff (reset) old_prn == exp_old)
        else report_mismatch("old_prn", 256'(exp_old), 256'(old_prn));
    check_stall: assert property (@(negedge clock) disable iff (reset) rename_stall == exp_stall)
        else report_mismatch("rename_stall", 256'(exp_stall), 256'(rename_stall));
    check_rval: assert property (@(negedge clock) disable iff (reset) read_value == exp_rval)
        else report_mismatch("read_value", 256'(exp_rval), 256'(read_value));
    check_rrdy: assert property (@(negedge clock) disable iff (reset) read_ready == exp_rrdy)
        else report_mismatch("read_ready", 256'(exp_rrdy), 256'(read_ready));
    check_wbval: assert property (@(negedge clock) disable iff (reset) wb_read_value == exp_wbval)
        else report_mismatch("wb_read_value", 256'(exp_wbval), 256'(wb_read_value));
    check_wbrdy: assert property (@(negedge clock) disable iff (reset) wb_read_ready == exp_wbrdy)
        else report_mismatch("wb_read_ready", 256'(exp_wbrdy), 256'(wb_read_ready));
    check_count: assert property (@(negedge clock) disable iff (reset) ready_count == exp_count)
        else report_mismatch("ready_count", 256'(exp_count), 256'(ready_count));

    always @(posedge clock) begin
        cycles <= cycles + 1;
        if (cycles >= max_cycles) begin
            $display("simulation ran past %0d cycles without finishing", max_cycles);
            $display("TB FAILED");
            $fatal(1, "timeout");
        end
    end

    // state after the edge from the inputs that were on the pins before it
    task automatic step();
        @(posedge clock);
        if (reset) begin
            for (int p = 0; p < phys_reg_sz; p++) begin
                ref_val[p] = '0;
                ref_rdy[p] = p < arch_reg_sz;
                fl[p] = PRN'(arch_reg_sz + p);
                if (p < arch_reg_sz) ref_map[p] = PRN'(p);
            end
            fl_head = 0;
            fl_tail = free_list_sz;
            pending.delete();
            return;
        end
        for (int i = 0; i < width; i++) begin
            if (write_prn[i] != '0) begin
                ref_val[write_prn[i]] = write_value[i];
                ref_rdy[write_prn[i]] = 1'b1;
            end
            if (commit_valid[i] && commit_old_prn[i] != '0) begin
                fl[fl_tail] = commit_old_prn[i];
                fl_tail++;
            end
        end
        // invalidation of new destinations comes last and wins
        for (int i = 0; i < width; i++) begin
            if (exp_dest[i] != '0) begin
                ref_map[rename_dest[i]] = exp_dest[i];
                ref_rdy[exp_dest[i]] = 1'b0;
                pending.push_back(exp_old[i]);
                fl_head++;
            end
        end
    endtask

    // renames is 0 for none, 1 for random, 2 for every lane
    task automatic pick_inputs(int arn_mask, int renames, bit commits, bit writes);
        for (int i = 0; i < width; i++) begin
            n_valid[i] = renames == 2 || (renames == 1 && next_random() % 4 != 0);
            n_dest[i] = ARN'(next_random() & arn_mask);
            n_src1[i] = ARN'(next_random() & arn_mask);
            n_src2[i] = ARN'(next_random() & arn_mask);
            n_commit[i] = commits && pending.size() > 0 && next_random() % 2 == 0;
            n_old[i] = n_commit[i] ? pending.pop_front() : PRN'(next_random());
            n_wprn[i] = writes ? PRN'(next_random()) : '0;
            n_wval[i] = DATA'((next_random() << 16) ^ next_random());
            n_wbprn[i] = n_wprn[i];
            n_rprn[2*i] = n_wprn[i];
            n_rprn[2*i+1] = PRN'(next_random());
        end
    endtask

    // drive the chosen inputs and predict what the DUT answers to them
    task automatic apply();
        int req;
        int k;
        req = 0;
        k = 0;
        for (int i = 0; i < width; i++) begin
            req += int'(n_valid[i] && n_dest[i] != '0);
        end
        exp_stall = fl_tail - fl_head < req;
        for (int i = 0; i < width; i++) begin
            exp_src1[i] = ref_map[n_src1[i]];
            exp_src2[i] = ref_map[n_src2[i]];
            exp_dest[i] = '0;
            exp_old[i] = '0;
            if (n_valid[i] && n_dest[i] != '0) begin
                exp_old[i] = ref_map[n_dest[i]];
                exp_dest[i] = exp_stall ? '0 : fl[fl_head + k];
                k++;
            end
            // later producers in the group override earlier ones
            for (int j = 0; j < i; j++) begin
                if (n_valid[j] && n_dest[j] != '0) begin
                    if (n_dest[j] == n_src1[i]) exp_src1[i] = exp_dest[j];
                    if (n_dest[j] == n_src2[i]) exp_src2[i] = exp_dest[j];
                    if (n_dest[j] == n_dest[i] && n_valid[i]) exp_old[i] = exp_dest[j];
                end
            end
            exp_wbval[i] = ref_val[n_wbprn[i]];
            exp_wbrdy[i] = ref_rdy[n_wbprn[i]];
        end
        for (int p = 0; p < 2 * width; p++) begin
            exp_rval[p] = ref_val[n_rprn[p]];
            exp_rrdy[p] = ref_rdy[n_rprn[p]];
            for (int j = 0; j < width; j++) begin
                if (n_wprn[j] != '0 && n_wprn[j] == n_rprn[p]) begin
                    exp_rval[p] = n_wval[j];
                    exp_rrdy[p] = 1'b1;
                end
            end
        end
        exp_count = cnt_w'($countones(ref_rdy));
        rename_valid <= n_valid;
        rename_dest <= n_dest;
        rename_src1 <= n_src1;
        rename_src2 <= n_src2;
        commit_valid <= n_commit;
        commit_old_prn <= n_old;
        write_prn <= n_wprn;
        write_value <= n_wval;
        read_prn <= n_rprn;
        wb_read_prn <= n_wbprn;
    endtask

    initial begin
        seed = 32'h616b_fe49;
        test_name = "reset";
        reset <= 1'b1;
        pick_inputs(31, 0, 0, 0);
        apply();
        repeat (4) step();
        reset <= 1'b0;
        // walk sources and reads over the architectural registers
        for (int c = 0; c < arch_reg_sz; c++) begin
            pick_inputs(31, 0, 0, 0);
            n_src1[0] = ARN'(c);
            for (int p = 0; p < 2 * width; p++) n_rprn[p] = PRN'((c + p) % arch_reg_sz);
            apply();
            step();
        end
        // few registers in play, so groups collide often
        test_name = "rename_group";
        repeat (12) begin
            pick_inputs(3, 1, 0, 0);
            apply();
            step();
        end
        test_name = "exhaust";
        repeat (20) begin
            pick_inputs(31, 2, 0, 0);
            apply();
            step();
        end
        test_name = "recycle";
        repeat (60) begin
            pick_inputs(31, 1, 1, 0);
            apply();
            step();
        end
        test_name = "writeback";
        for (int c = 0; c < 40; c++) begin
            pick_inputs(31, 0, 0, 1);
            if (c % 5 == 0) begin
                n_wprn[width-1] = '0;
                n_rprn[2*width-2] = '0;
            end
            apply();
            step();
        end
        test_name = "random_mix";
        repeat (600) begin
            pick_inputs(31, 1, 1, 1);
            // write the register that lane 0 is about to allocate
            if (next_random() % 8 == 0 && n_valid[0] && n_dest[0] != '0) begin
                n_wprn[0] = fl[fl_head];
                n_rprn[0] = fl[fl_head];
            end
            apply();
            step();
        end
        $display("TB PASSED");
        $finish;
    end

endmodule

// ==== verilog.f ====
src/rename_pkg.sv
src/prf.sv
src/free_list.sv
src/map_table.sv
src/rename_top.sv
testbench/tb_rename_top.sv
